// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Program store depth in words
`define IMEM_WORDS 64

// Data RAM depth in words
`define DMEM_WORDS 16

`define XLEN 32

`define HALT_PC (`IMEM_WORDS * 4)  // First byte address past the program store

`endif

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    // One fetched word, read through whichever format the opcode calls for
    typedef union packed {
        logic [31:0] raw;
        rType_t      r;
        iType_t      i;
        sType_t      s;
        bType_t      b;
    } instWord_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    localparam logic [2:0] F3_ADD = 3'b000;  // Also sub
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Bit 30 set turns add into sub
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// File: logic/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT
    } aluOp_t;

    // Branch condition tested on the ALU zero flag
    typedef enum logic [1:0] {
        NONE,
        EQ,
        NE
    } branchKind_t;

    // Write-back source
    typedef enum logic {
        ALU,
        MEM
    } wbSrc_t;

endpackage

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none

`include "cpu_consts.svh"

module fetchUnit (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                    progData,
    input  logic                           stall,
    input  ctrlPkg::branchKind_t           branchKind,
    input  logic                           zero,
    input  logic [`XLEN-1:0]               imm,
    output logic [31:0]                    pc,
    output isaPkg::instWord_t              inst,
    output logic                           halted,
    output logic                           retireValid
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic [31:0] progStore [`IMEM_WORDS];
    logic        running;  // Low in the reset cycles only
    logic        taken;
    logic        advance;
    logic [31:0] nextPc;

    // Load port, used while the core sits in reset
    always_ff @(posedge CLK) begin
        if (progWe) begin
            progStore[progAddr] <= progData;
        end
    end

    assign halted = (pc == `HALT_PC);

    // Feed a zero word when not executing, it decodes as no operation
    assign inst = (running && !halted) ? progStore[pc[AW+1:2]] : '0;

    assign taken = ((branchKind == ctrlPkg::EQ) && zero) ||
                   ((branchKind == ctrlPkg::NE) && !zero);
    assign nextPc = taken ? pc + imm : pc + 32'd4;

    assign advance     = running && !halted && !stall;
    assign retireValid = advance;  // One retire per pc step

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (advance) begin
                pc <= nextPc;
            end
        end
    end

    // Branch offsets from the decoder must keep the pc on word boundaries
    pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: logic/controlDecoder.sv
`default_nettype none

`include "cpu_consts.svh"

module controlDecoder (
    input  isaPkg::instWord_t    inst,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [`XLEN-1:0]     imm,
    output ctrlPkg::aluOp_t      aluOp,
    output logic                 aluSrcImm,
    output ctrlPkg::branchKind_t branchKind,
    output logic                 memRead,
    output logic                 memWrite,
    output ctrlPkg::wbSrc_t      wbSrc,
    output logic                 regWrite
);

    ctrlPkg::aluOp_t aluFromF3;
    logic            f3Known;
    logic            altSel;

    // Only register-register ops honour the alternate bit
    assign altSel = (inst.r.opcode == isaPkg::OP) && (inst.r.funct7 == isaPkg::F7_ALT);

    always_comb begin
        f3Known   = 1'b1;
        aluFromF3 = ctrlPkg::ADD;
        case (inst.r.funct3)
            isaPkg::F3_ADD: aluFromF3 = altSel ? ctrlPkg::SUB : ctrlPkg::ADD;
            isaPkg::F3_SLT: aluFromF3 = ctrlPkg::SLT;
            isaPkg::F3_XOR: aluFromF3 = ctrlPkg::XOR;
            isaPkg::F3_OR:  aluFromF3 = ctrlPkg::OR;
            isaPkg::F3_AND: aluFromF3 = ctrlPkg::AND;
            default:        f3Known   = 1'b0;
        endcase
    end

    always_comb begin
        rs1        = inst.r.rs1;  // Register fields sit at the same bits in every format
        rs2        = inst.r.rs2;
        rd         = inst.r.rd;
        imm        = '0;
        aluOp      = ctrlPkg::ADD;
        aluSrcImm  = 1'b0;
        branchKind = ctrlPkg::NONE;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        wbSrc      = ctrlPkg::ALU;
        regWrite   = 1'b0;
        case (inst.r.opcode)
            isaPkg::OP: begin
                aluOp    = aluFromF3;
                regWrite = f3Known;
            end
            isaPkg::OPIMM: begin
                imm       = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
                aluOp     = aluFromF3;
                aluSrcImm = 1'b1;
                regWrite  = f3Known;
            end
            isaPkg::LOAD: begin
                imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
                if (inst.i.funct3 == isaPkg::F3_LW) begin
                    aluSrcImm = 1'b1;
                    memRead   = 1'b1;
                    wbSrc     = ctrlPkg::MEM;
                    regWrite  = 1'b1;
                end
            end
            isaPkg::STORE: begin
                imm = {{(`XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
                if (inst.s.funct3 == isaPkg::F3_SW) begin
                    aluSrcImm = 1'b1;
                    memWrite  = 1'b1;
                end
            end
            isaPkg::BRANCH: begin
                imm   = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10to5,
                         inst.b.imm4to1, 1'b0};
                aluOp = ctrlPkg::SUB;  // Equality through the zero flag
                if (inst.b.funct3 == isaPkg::F3_BEQ) begin
                    branchKind = ctrlPkg::EQ;
                end else if (inst.b.funct3 == isaPkg::F3_BNE) begin
                    branchKind = ctrlPkg::NE;
                end
            end
            default: ;  // No operation
        endcase
    end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`default_nettype none

`include "cpu_consts.svh"

module registerFile (
    input  logic             CLK,
    input  logic             rst,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] wrData,
    input  logic             regWrite,
    input  logic             stall,
    output logic [`XLEN-1:0] rdData1,
    output logic [`XLEN-1:0] rdData2
);

    logic [`XLEN-1:0] regs [32];  // Entry 0 is cleared at reset and never written

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && !stall && (rd != 5'd0)) begin
            regs[rd] <= wrData;  // Write lands on the retiring edge
        end
    end

    assign rdData1 = regs[rs1];
    assign rdData2 = regs[rs2];

    x0ReadsZero: assert property (@(posedge CLK) disable iff (rst)
        (rs1 == 5'd0) |-> (rdData1 == '0));

endmodule

`default_nettype wire

// File: logic/aluUnit.sv
`default_nettype none

`include "cpu_consts.svh"

module aluUnit (
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  logic [`XLEN-1:0] imm,
    input  logic             aluSrcImm,
    input  ctrlPkg::aluOp_t  aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [`XLEN-1:0] srcB;

    assign srcB = aluSrcImm ? imm : opB;

    always_comb begin
        case (aluOp)
            ctrlPkg::ADD: result = opA + srcB;
            ctrlPkg::SUB: result = opA - srcB;
            ctrlPkg::AND: result = opA & srcB;
            ctrlPkg::OR:  result = opA | srcB;
            ctrlPkg::XOR: result = opA ^ srcB;
            // Signed compare, result is 0 or 1
            ctrlPkg::SLT: result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(srcB)};
            default:      result = '0;
        endcase
    end

    assign zero = (result == '0);  // Branch condition

endmodule

`default_nettype wire

// File: logic/loadStoreUnit.sv
`default_nettype none

`include "cpu_consts.svh"

module loadStoreUnit (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           memRead,
    input  logic                           memWrite,
    input  ctrlPkg::wbSrc_t                wbSrc,
    input  logic [`XLEN-1:0]               aluResult,
    input  logic [`XLEN-1:0]               storeData,
    input  logic                           ack,
    input  logic [`XLEN-1:0]               datR,
    output logic                           cyc,
    output logic                           stb,
    output logic                           we,
    output logic [$clog2(`DMEM_WORDS)-1:0] adr,
    output logic [`XLEN-1:0]               datW,
    output logic [`XLEN-1:0]               wbData,
    output logic                           stall
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic memOp;

    assign memOp = memRead || memWrite;

    // Held for as long as the instruction sits in decode
    assign cyc  = memOp;
    assign stb  = memOp;
    assign we   = memWrite;
    assign adr  = aluResult[AW+1:2];  // Word index, wraps at the RAM size
    assign datW = storeData;

    // Core waits until the RAM acks
    assign stall = memOp && !ack;

    assign wbData = (wbSrc == ctrlPkg::MEM) ? datR : aluResult;

    // Fetch and register file hold still while the request is open
    reqHeld: assert property (@(posedge CLK) disable iff (rst)
        (stb && !ack) |=> (cyc && stb && $stable(adr) && $stable(we) && $stable(datW)));

endmodule

`default_nettype wire

// File: logic/dataRam.sv
`default_nettype none

`include "cpu_consts.svh"

module dataRam (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [$clog2(`DMEM_WORDS)-1:0] adr,
    input  logic [`XLEN-1:0]               datW,
    output logic                           ack,
    output logic [`XLEN-1:0]               datR
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic             take;

    // New request seen, ack goes out next cycle
    assign take = cyc && stb && !ack;

    always_ff @(posedge CLK) begin
        if (rst) begin
            ack <= 1'b0;
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack <= take;
            if (take && we) begin
                mem[adr] <= datW;
            end
        end
    end

    // Old contents, valid while ack is high
    always_ff @(posedge CLK) begin
        if (take) begin
            datR <= mem[adr];
        end
    end

    // Ack lands while the master still holds its request
    ackDuringStb: assert property (@(posedge CLK) disable iff (rst) ack |-> (cyc && stb));

endmodule

`default_nettype wire

// File: logic/singleCpu.sv
`default_nettype none

`include "cpu_consts.svh"

module singleCpu (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                    progData,
    output logic                           halted,
    output logic                           retireValid,
    output logic [31:0]                    retirePc,
    output logic                           retireWe,
    output logic [4:0]                     retireRd,
    output logic [`XLEN-1:0]               retireData
);

    logic [31:0]          pc;
    isaPkg::instWord_t    inst;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic [`XLEN-1:0]     imm;
    ctrlPkg::aluOp_t      aluOp;
    logic                 aluSrcImm;
    ctrlPkg::branchKind_t branchKind;
    logic                 memRead;
    logic                 memWrite;
    ctrlPkg::wbSrc_t      wbSrc;
    logic                 regWrite;
    logic [`XLEN-1:0]     rdData1;
    logic [`XLEN-1:0]     rdData2;
    logic [`XLEN-1:0]     aluResult;
    logic                 zero;
    logic [`XLEN-1:0]     wbData;
    logic                 stall;

    // Data bus between load/store unit and RAM
    logic                           cyc;
    logic                           stb;
    logic                           we;
    logic [$clog2(`DMEM_WORDS)-1:0] adr;
    logic [`XLEN-1:0]               datW;
    logic                           ack;
    logic [`XLEN-1:0]               datR;

    fetchUnit fetch (
        .CLK(CLK), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stall(stall), .branchKind(branchKind), .zero(zero), .imm(imm),
        .pc(pc), .inst(inst), .halted(halted), .retireValid(retireValid)
    );

    controlDecoder decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .branchKind(branchKind),
        .memRead(memRead), .memWrite(memWrite), .wbSrc(wbSrc), .regWrite(regWrite)
    );

    registerFile regs (
        .CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .wrData(wbData),
        .regWrite(regWrite), .stall(stall), .rdData1(rdData1), .rdData2(rdData2)
    );

    aluUnit alu (
        .opA(rdData1), .opB(rdData2), .imm(imm), .aluSrcImm(aluSrcImm),
        .aluOp(aluOp), .result(aluResult), .zero(zero)
    );

    loadStoreUnit lsu (
        .CLK(CLK), .rst(rst), .memRead(memRead), .memWrite(memWrite), .wbSrc(wbSrc),
        .aluResult(aluResult), .storeData(rdData2), .ack(ack), .datR(datR),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .wbData(wbData), .stall(stall)
    );

    dataRam dmem (
        .CLK(CLK), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .ack(ack), .datR(datR)
    );

    // Retire port mirrors the register write port
    assign retirePc   = pc;
    assign retireWe   = regWrite;
    assign retireRd   = rd;
    assign retireData = wbData;

endmodule

`default_nettype wire

// File: tb/singleCpuTb.sv
`default_nettype none

`include "cpu_consts.svh"

module singleCpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IAW            = $clog2(`IMEM_WORDS);
    localparam int TIMEOUT_CYCLES = 2 * `IMEM_WORDS + 20;

    // Instruction kinds of the random program, one per 4-bit draw
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_ADDI = 6;
    localparam int K_ANDI = 7;
    localparam int K_ORI  = 8;
    localparam int K_XORI = 9;
    localparam int K_LW   = 10;  // Draws 10 and 11
    localparam int K_SW   = 12;  // Draws 12 and 13
    localparam int K_BEQ  = 14;
    localparam int K_BNE  = 15;

    logic             CLK;
    logic             rst;
    logic             progWe;
    logic [IAW-1:0]   progAddr;
    logic [31:0]      progData;
    logic             halted;
    logic             retireValid;
    logic [31:0]      retirePc;
    logic             retireWe;
    logic [4:0]       retireRd;
    logic [`XLEN-1:0] retireData;

    // Program image plus the fields the model works from
    logic [31:0]      progImage [`IMEM_WORDS];
    int               kindOf    [`IMEM_WORDS];
    logic [4:0]       rdOf      [`IMEM_WORDS];
    logic [4:0]       rs1Of     [`IMEM_WORDS];
    logic [4:0]       rs2Of     [`IMEM_WORDS];
    logic [`XLEN-1:0] immOf     [`IMEM_WORDS];

    // Reference model state
    logic [`XLEN-1:0] mRegs   [32];
    logic [`XLEN-1:0] mMem    [`DMEM_WORDS];
    logic             mStored [`DMEM_WORDS];
    logic [31:0]      mPc;
    int               idle;        // Cycles without retire since the last one
    int               cycleCount;
    int               warmLoads;
    int               coldLoads;
    logic [31:0]      lfsrState = 32'h2ac4;

    singleCpu dut (
        .CLK(CLK), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .halted(halted), .retireValid(retireValid), .retirePc(retirePc),
        .retireWe(retireWe), .retireRd(retireRd), .retireData(retireData)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], nextBit()};
        end
        return r;
    endfunction

    function automatic logic [2:0] aluF3(input int kind);
        case (kind)
            K_AND, K_ANDI: return isaPkg::F3_AND;
            K_OR, K_ORI:   return isaPkg::F3_OR;
            K_XOR, K_XORI: return isaPkg::F3_XOR;
            K_SLT:         return isaPkg::F3_SLT;
            default:       return isaPkg::F3_ADD;  // add and sub
        endcase
    endfunction

    task automatic buildProgram();
        isaPkg::instWord_t w;
        int                kind;
        logic [11:0]       imm12;
        logic [12:0]       off;
        for (int a = 0; a < `IMEM_WORDS; a++) begin
            kind = int'(randBits(4));
            if (kind == K_LW + 1 || kind == K_SW + 1) begin
                kind = kind - 1;
            end
            rdOf[a]  = 5'(randBits(5));
            rs1Of[a] = 5'(randBits(5));
            rs2Of[a] = 5'(randBits(5));
            imm12    = 12'(randBits(12));
            w.raw    = '0;
            if (kind <= K_SLT) begin
                w.r.opcode = isaPkg::OP;
                w.r.funct7 = (kind == K_SUB) ? isaPkg::F7_ALT : 7'd0;
                w.r.funct3 = aluF3(kind);
                w.r.rd     = rdOf[a];
                w.r.rs1    = rs1Of[a];
                w.r.rs2    = rs2Of[a];
                immOf[a]   = '0;
            end else if (kind <= K_XORI) begin
                w.i.opcode = isaPkg::OPIMM;
                w.i.funct3 = aluF3(kind);
                w.i.rd     = rdOf[a];
                w.i.rs1    = rs1Of[a];
                w.i.imm    = imm12;
                immOf[a]   = `XLEN'(signed'(imm12));
            end else if (kind == K_LW || kind == K_SW) begin
                // x0 base, word offset inside the data RAM
                rs1Of[a] = 5'd0;
                imm12    = 12'(4 * int'(randBits($clog2(`DMEM_WORDS))));
                immOf[a] = `XLEN'(imm12);
                if (kind == K_LW) begin
                    w.i.opcode = isaPkg::LOAD;
                    w.i.funct3 = isaPkg::F3_LW;
                    w.i.rd     = rdOf[a];
                    w.i.imm    = imm12;
                end else begin
                    w.s.opcode = isaPkg::STORE;
                    w.s.funct3 = isaPkg::F3_SW;
                    w.s.rs2    = rs2Of[a];
                    w.s.immHi  = imm12[11:5];
                    w.s.immLo  = imm12[4:0];
                end
            end else begin
                // Forward only, lands at most on the halt address
                off = 13'(4 * (1 + int'(randBits(IAW)) % (`IMEM_WORDS - a)));
                immOf[a]     = `XLEN'(off);
                w.b.opcode   = isaPkg::BRANCH;
                w.b.funct3   = (kind == K_BEQ) ? isaPkg::F3_BEQ : isaPkg::F3_BNE;
                w.b.rs1      = rs1Of[a];
                w.b.rs2      = rs2Of[a];
                w.b.imm12    = off[12];
                w.b.imm11    = off[11];
                w.b.imm10to5 = off[10:5];
                w.b.imm4to1  = off[4:1];
            end
            kindOf[a]    = kind;
            progImage[a] = w.raw;
        end
    endtask

    task automatic stopRun();
        $display("Test failures found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkIndex(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stopRun();
        end
    endtask

    // One model step per observed retire
    task automatic stepModel();
        int               a;
        int               kind;
        int               word;
        logic [`XLEN-1:0] opA;
        logic [`XLEN-1:0] opB;
        logic [`XLEN-1:0] res;
        logic             expWe;
        logic [31:0]      nextPc;
        a      = int'(mPc >> 2);
        kind   = kindOf[a];
        opA    = mRegs[rs1Of[a]];
        opB    = (kind <= K_SLT) ? mRegs[rs2Of[a]] : immOf[a];
        word   = int'(immOf[a] >> 2);
        res    = '0;
        expWe  = 1'b1;
        nextPc = mPc + 32'd4;
        case (kind)
            K_ADD, K_ADDI: res = opA + opB;
            K_SUB:         res = opA - opB;
            K_AND, K_ANDI: res = opA & opB;
            K_OR, K_ORI:   res = opA | opB;
            K_XOR, K_XORI: res = opA ^ opB;
            K_SLT:         res = ($signed(opA) < $signed(opB)) ? `XLEN'(1) : '0;
            K_LW: begin
                res = mMem[word];
                if (mStored[word]) begin
                    warmLoads++;
                end else begin
                    coldLoads++;
                end
            end
            K_SW: begin
                expWe         = 1'b0;
                mMem[word]    = mRegs[rs2Of[a]];
                mStored[word] = 1'b1;
            end
            default: begin
                expWe = 1'b0;
                if ((opA == mRegs[rs2Of[a]]) == (kind == K_BEQ)) begin
                    nextPc = mPc + immOf[a];  // Taken
                end
            end
        endcase
        // lw and sw spend exactly one stalled cycle first
        checkCount(idle, (kind == K_LW || kind == K_SW) ? 1 : 0, "idle cycles before retire");
        checkWord(retirePc, mPc, "retirePc");
        checkBit(retireWe, expWe, "retireWe");
        if (expWe) begin
            checkIndex(retireRd, rdOf[a], "retireRd");
            checkWord(retireData, res, "retireData");
            if (rdOf[a] != 5'd0) begin
                mRegs[rdOf[a]] = res;
            end
        end
        mPc = nextPc;
    endtask

    always @(posedge CLK) begin
        if (rst) begin
            cycleCount <= 0;
        end else if (cycleCount == TIMEOUT_CYCLES) begin
            $display("Timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
            stopRun();
        end else begin
            cycleCount <= cycleCount + 1;
        end
    end

    initial begin
        rst       = 1'b1;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        mPc       = '0;
        idle      = 0;
        warmLoads = 0;
        coldLoads = 0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mMem[i]    = '0;
            mStored[i] = 1'b0;
        end
        buildProgram();

        // Program load while the core sits in reset
        for (int a = 0; a < `IMEM_WORDS; a++) begin
            @(posedge CLK);
            #10;
            progWe   = 1'b1;
            progAddr = IAW'(a);
            progData = progImage[a];
        end
        @(posedge CLK);
        #10;
        progWe = 1'b0;
        repeat (5) @(posedge CLK);
        #10;
        rst = 1'b0;

        @(negedge CLK);  // First cycle out of reset fetches nothing
        checkBit(halted, 1'b0, "halted after reset");
        checkBit(retireValid, 1'b0, "retireValid after reset");

        while (mPc != `HALT_PC) begin
            @(negedge CLK);
            checkBit(halted, 1'b0, "halted");
            if (retireValid) begin
                stepModel();
                idle = 0;
            end else begin
                idle++;
            end
        end

        // Parked at the halt address
        repeat (4) begin
            @(negedge CLK);
            checkBit(halted, 1'b1, "halted");
            checkBit(retireValid, 1'b0, "retireValid after halt");
        end
        $display("Loads of stored words: %0d, of unwritten words: %0d", warmLoads, coldLoads);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/fetchUnit.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/loadStoreUnit.sv
logic/dataRam.sv
logic/singleCpu.sv
tb/singleCpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module singleCpuTb -o singleCpuSim
./obj_dir/singleCpuSim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failures"
